// ==== tb.f ====
rtl/imul_pkg.sv
rtl/mul_operand_if.sv
rtl/mul_req_stage.sv
rtl/mul_operand_queue.sv
rtl/mul_iter_ctrl.sv
rtl/mul_iter_dpath.sv
rtl/mul_unit_top.sv
bench/tb_mul_unit.sv

// ==== bench/tb_mul_unit.sv ====
/*
  tb_mul_unit: directed testbench for the iterative signed multiply
  unit, with a signed reference model and an LFSR for operands
*/

`timescale 1ns/100ps

module tb_mul_unit;

  logic               clk;
  logic               reset;
  imul_pkg::operand_t mulreq_msg_a;
  imul_pkg::operand_t mulreq_msg_b;
  logic               mulreq_val;
  logic               mulreq_rdy;
  imul_pkg::result_t  mulresp_msg_result;
  logic               mulresp_val;
  logic               mulresp_rdy;

  // pairs still to send, and products owed in request order
  imul_pkg::operand_t pend_a[$];
  imul_pkg::operand_t pend_b[$];
  imul_pkg::result_t  exp_q[$];

  logic [31:0] lfsr_state = 32'd73;

  mul_unit_top DUT (
    .clk                (clk),
    .reset              (reset),
    .mulreq_msg_a       (mulreq_msg_a),
    .mulreq_msg_b       (mulreq_msg_b),
    .mulreq_val         (mulreq_val),
    .mulreq_rdy         (mulreq_rdy),
    .mulresp_msg_result (mulresp_msg_result),
    .mulresp_val        (mulresp_val),
    .mulresp_rdy        (mulresp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  // fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic imul_pkg::operand_t rand_word();
    imul_pkg::operand_t w;
    for (int i = 0; i < imul_pkg::op_width; i++) begin
      w = {w[imul_pkg::op_width-2:0], next_rand_bit()};
    end
    return w;
  endfunction

  // full signed product, both operands sign-extended to 64 bits
  function automatic imul_pkg::result_t ref_product(input imul_pkg::operand_t a,
                                                    input imul_pkg::operand_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    sa = $signed(a);
    sb = $signed(b);
    return sa * sb;
  endfunction

  task automatic check_result(input string name, input imul_pkg::result_t expected,
                              input imul_pkg::result_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
      abort_run("product mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
      abort_run("control bit mismatch");
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
      abort_run("count mismatch");
    end
  endtask

  // sends everything pending and collects every owed product
  // inputs change on the falling edge, a transfer happens on the next rising edge
  task automatic stream_requests(input bit stall, input string label);
    int cycles;
    int target;
    int received;
    imul_pkg::operand_t a;
    imul_pkg::operand_t b;
    target   = pend_a.size() + exp_q.size();
    received = 0;
    cycles   = 0;
    while (received < target) begin
      @(negedge clk);
      cycles++;
      if (cycles > target * 100 + 200) abort_run({"timeout waiting for responses in ", label});
      mulreq_val = (pend_a.size() > 0);
      if (mulreq_val) begin
        mulreq_msg_a = pend_a[0];
        mulreq_msg_b = pend_b[0];
      end
      mulresp_rdy = stall ? next_rand_bit() : 1'b1;
      // response first, so a product never matches the request sent beside it
      if (mulresp_val && mulresp_rdy) begin
        if (exp_q.size() == 0) abort_run({"response with no request behind it in ", label});
        check_result("mulresp_msg_result", exp_q.pop_front(), mulresp_msg_result);
        received++;
      end
      if (mulreq_val && mulreq_rdy) begin
        a = pend_a.pop_front();
        b = pend_b.pop_front();
        exp_q.push_back(ref_product(a, b));
      end
    end
    @(negedge clk);
    mulreq_val  = 1'b0;
    mulresp_rdy = 1'b1;
    // no repeated response once everything is drained
    for (int i = 0; i < 40; i++) begin
      @(negedge clk);
      check_bit("mulresp_val", 1'b0, mulresp_val);
    end
  endtask

  // one request on an empty unit, latency counted from the accepting edge
  task automatic run_single(input imul_pkg::operand_t a, input imul_pkg::operand_t b);
    int latency;
    @(negedge clk);
    mulreq_msg_a = a;
    mulreq_msg_b = b;
    mulreq_val   = 1'b1;
    mulresp_rdy  = 1'b1;
    check_bit("mulreq_rdy", 1'b1, mulreq_rdy);
    latency = -1;
    do begin
      @(negedge clk);
      mulreq_val = 1'b0;
      latency++;
      if (latency > 200) abort_run("timeout waiting for mulresp_val in test_corners");
    end while (!mulresp_val);
    check_count("response latency", 35, latency);
    check_result("mulresp_msg_result", ref_product(a, b), mulresp_msg_result);
    // taken on the next edge, so valid must drop
    @(negedge clk);
    check_bit("mulresp_val", 1'b0, mulresp_val);
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------

  task automatic test_reset();
    check_bit("mulreq_rdy", 1'b1, mulreq_rdy);
    check_bit("mulresp_val", 1'b0, mulresp_val);
  endtask

  task automatic test_corners();
    run_single(32'h0000_0000, rand_word());
    run_single(32'h0000_0001, 32'hffff_ffff);
    run_single(32'hffff_ffff, 32'hffff_ffff);
    run_single(32'h8000_0000, 32'h8000_0000);
    run_single(32'h8000_0000, 32'h0000_0001);
    run_single(32'h7fff_ffff, 32'h7fff_ffff);
  endtask

  task automatic test_burst();
    for (int i = 0; i < 20; i++) begin
      pend_a.push_back(rand_word());
      pend_b.push_back(rand_word());
    end
    stream_requests(1'b0, "test_burst");
  endtask

  task automatic test_backpressure();
    imul_pkg::operand_t a;
    imul_pkg::operand_t b;
    int accepted;
    int low_run;
    int cycles;
    a        = rand_word();
    b        = rand_word();
    accepted = 0;
    low_run  = 0;
    cycles   = 0;
    while (low_run < 100) begin
      @(negedge clk);
      cycles++;
      if (cycles > 1000) abort_run("timeout waiting for mulreq_rdy to stay low");
      mulresp_rdy  = 1'b0;
      mulreq_msg_a = a;
      mulreq_msg_b = b;
      mulreq_val   = 1'b1;
      // stalled response must keep showing the oldest product
      if (mulresp_val) begin
        if (exp_q.size() == 0) abort_run("response with no request behind it under stall");
        check_result("mulresp_msg_result", exp_q[0], mulresp_msg_result);
      end
      if (mulreq_rdy) begin
        exp_q.push_back(ref_product(a, b));
        accepted++;
        low_run = 0;
        a = rand_word();
        b = rand_word();
      end else begin
        low_run++;
      end
    end
    check_count("accepted requests", 6, accepted);
    check_bit("mulresp_val", 1'b1, mulresp_val);
    // drop the refused pair and drain
    stream_requests(1'b0, "test_backpressure");
  endtask

  task automatic test_random_stall();
    for (int i = 0; i < 40; i++) begin
      pend_a.push_back(rand_word());
      pend_b.push_back(rand_word());
    end
    stream_requests(1'b1, "test_random_stall");
  endtask

  // ----------------------------------------
  // sequence
  // ----------------------------------------

  initial begin
    reset        = 1'b1;
    mulreq_msg_a = '0;
    mulreq_msg_b = '0;
    mulreq_val   = 1'b0;
    mulresp_rdy  = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    test_reset();
    test_corners();
    test_burst();
    test_backpressure();
    test_random_stall();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== rtl/mul_unit_top.sv ====
/*
  mul_unit_top: signed 32x32 iterative multiply unit with
  val/rdy request and response ports
*/

`timescale 1ns/100ps

module mul_unit_top (
  input  logic               clk,
  input  logic               reset,
  input  imul_pkg::operand_t mulreq_msg_a,
  input  imul_pkg::operand_t mulreq_msg_b,
  input  logic               mulreq_val,
  output logic               mulreq_rdy,
  output imul_pkg::result_t  mulresp_msg_result,
  output logic               mulresp_val,
  input  logic               mulresp_rdy
);

  // request stage to queue, and queue to multiplier
  mul_operand_if stage_q ();
  mul_operand_if q_mul ();

  // ctrl to dpath
  logic load;
  logic step;
  logic add_en;

  // dpath status back to ctrl
  logic count_zero;
  logic b_lsb;

  // ----------------------------------------
  // request path
  // ----------------------------------------

  mul_req_stage u_req_stage (
    .clk          (clk),
    .reset        (reset),
    .mulreq_msg_a (mulreq_msg_a),
    .mulreq_msg_b (mulreq_msg_b),
    .mulreq_val   (mulreq_val),
    .mulreq_rdy   (mulreq_rdy),
    .out          (stage_q.src)
  );

  mul_operand_queue u_queue (
    .clk   (clk),
    .reset (reset),
    .in    (stage_q.dst),
    .out   (q_mul.src)
  );

  // ----------------------------------------
  // iterative multiplier
  // ----------------------------------------

  // the queue head feeds the dpath, the ctrl answers the handshake
  mul_iter_ctrl u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .op_val      (q_mul.val),
    .op_rdy      (q_mul.rdy),
    .mulresp_val (mulresp_val),
    .mulresp_rdy (mulresp_rdy),
    .count_zero  (count_zero),
    .b_lsb       (b_lsb),
    .load        (load),
    .step        (step),
    .add_en      (add_en)
  );

  mul_iter_dpath u_dpath (
    .clk                (clk),
    .reset              (reset),
    .a_mag              (q_mul.a_mag),
    .b_mag              (q_mul.b_mag),
    .neg                (q_mul.neg),
    .load               (load),
    .step               (step),
    .add_en             (add_en),
    .count_zero         (count_zero),
    .b_lsb              (b_lsb),
    .mulresp_msg_result (mulresp_msg_result)
  );

endmodule

// ==== rtl/mul_iter_dpath.sv ====
/*
  mul_iter_dpath: shift-add datapath for one unsigned magnitude
  product, with the result sign applied at the output
*/

`timescale 1ns/100ps

module mul_iter_dpath (
  input  logic               clk,
  input  logic               reset,
  input  imul_pkg::operand_t a_mag,
  input  imul_pkg::operand_t b_mag,
  input  logic               neg,
  input  logic               load,
  input  logic               step,
  input  logic               add_en,
  output logic               count_zero,
  output logic               b_lsb,
  output imul_pkg::result_t  mulresp_msg_result
);

  // ----------------------------------------
  // registers
  // ----------------------------------------

  // multiplicand, shifted left one place per step
  imul_pkg::result_t  mcand_q;

  // multiplier, shifted right so bit 0 is the current bit
  imul_pkg::operand_t mplier_q;

  // running sum of partial products
  imul_pkg::result_t  acc_q;

  logic               neg_q;
  logic [imul_pkg::cnt_width-1:0] cnt_q;

  imul_pkg::result_t  acc_next;

  // partial product is added only for a set multiplier bit
  assign acc_next = add_en ? (acc_q + mcand_q) : acc_q;

  // ----------------------------------------
  // step counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (load) begin
      // all ones is op_width - 1, so 32 steps down to zero
      cnt_q <= '1;
    end else if (step) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign count_zero = (cnt_q == '0);

  // ----------------------------------------
  // operands and accumulator
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      // magnitude is unsigned, cast zero-extends into 64 bits
      mcand_q  <= imul_pkg::result_t'(a_mag);
      mplier_q <= b_mag;
      neg_q    <= neg;
      acc_q    <= '0;
    end else if (step) begin
      acc_q    <= acc_next;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign b_lsb = mplier_q[0];

  // ----------------------------------------
  // result
  // ----------------------------------------

  // two's complement negate when the operand signs differed
  // magnitude product is below 2**63 so the negation never overflows
  assign mulresp_msg_result = neg_q ? (~acc_q + 1'b1) : acc_q;

endmodule

// ==== rtl/mul_iter_ctrl.sv ====
/*
  mul_iter_ctrl: idle / calculate / done FSM that pops one operand
  pair, runs the shift-add steps and presents the response
*/

`timescale 1ns/100ps

module mul_iter_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic op_val,
  output logic op_rdy,
  output logic mulresp_val,
  input  logic mulresp_rdy,
  input  logic count_zero,
  input  logic b_lsb,
  output logic load,
  output logic step,
  output logic add_en
);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } state_t;

  state_t state_q;
  logic   resp_val_q;
  logic   resp_take;

  // ----------------------------------------
  // datapath controls
  // ----------------------------------------

  // only an idle multiplier pulls from the queue
  assign op_rdy = (state_q == st_idle);
  assign load   = op_val && op_rdy;

  // one shift-add step per calculate cycle
  assign step   = (state_q == st_calc);
  assign add_en = step && b_lsb;

  assign resp_take   = resp_val_q && mulresp_rdy;
  assign mulresp_val = resp_val_q;

  // ----------------------------------------
  // state register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: if (load) state_q <= st_calc;
        // last step happens on the edge that leaves calculate
        st_calc: if (count_zero) state_q <= st_done;
        st_done: if (resp_take) state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  // response valid is registered, rises one cycle into done
  // and drops on the edge the response is taken
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val_q <= 1'b0;
    end else begin
      resp_val_q <= (state_q == st_done) && !resp_take;
    end
  end

  // accumulator is still moving during calculate
  // a load must give exactly op_width steps with no response before them
  a_no_early_resp: assert property (@(posedge clk) disable iff (reset)
    load |=> (step && !mulresp_val) [*imul_pkg::op_width] ##1 !step);

endmodule

// ==== rtl/mul_operand_queue.sv ====
/*
  mul_operand_queue: circular FIFO of prepared operand pairs
  between the request stage and the multiplier
*/

`timescale 1ns/100ps

module mul_operand_queue (
  input  logic       clk,
  input  logic       reset,
  mul_operand_if.dst in,
  mul_operand_if.src out
);

  // ----------------------------------------
  // storage
  // ----------------------------------------

  // one array per field of the entry
  imul_pkg::operand_t a_mem [imul_pkg::queue_depth];
  imul_pkg::operand_t b_mem [imul_pkg::queue_depth];
  logic               neg_mem [imul_pkg::queue_depth];

  logic [imul_pkg::queue_ptr_width-1:0] wr_ptr_q;
  logic [imul_pkg::queue_ptr_width-1:0] rd_ptr_q;

  // one extra bit so a full queue is distinct from empty
  logic [imul_pkg::queue_ptr_width:0]   count_q;

  logic push;
  logic pop;
  logic full;
  logic empty;

  assign full  = (count_q == imul_pkg::queue_depth);
  assign empty = (count_q == '0);

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  assign pop  = out.val && out.rdy;
  assign push = in.val && in.rdy;

  // full queue still takes an item when the head leaves on this edge
  assign in.rdy  = !full || pop;
  assign out.val = !empty;

  // head entry is always presented
  assign out.a_mag = a_mem[rd_ptr_q];
  assign out.b_mag = b_mem[rd_ptr_q];
  assign out.neg   = neg_mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push) begin
      a_mem[wr_ptr_q]   <= in.a_mag;
      b_mem[wr_ptr_q]   <= in.b_mag;
      neg_mem[wr_ptr_q] <= in.neg;
    end
  end

  // ----------------------------------------
  // pointers and occupancy
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // depth is a power of two, pointers wrap on overflow
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // occupancy stays within the storage
  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    count_q <= imul_pkg::queue_depth);

endmodule

// ==== rtl/mul_req_stage.sv ====
/*
  mul_req_stage: accepts a signed operand pair, stores magnitudes
  and the result sign, holds the item until the queue takes it
*/

`timescale 1ns/100ps

module mul_req_stage (
  input  logic               clk,
  input  logic               reset,
  input  imul_pkg::operand_t mulreq_msg_a,
  input  imul_pkg::operand_t mulreq_msg_b,
  input  logic               mulreq_val,
  output logic               mulreq_rdy,
  mul_operand_if.src         out
);

  logic               stage_val_q;
  imul_pkg::operand_t a_mag_q;
  imul_pkg::operand_t b_mag_q;
  logic               neg_q;
  logic               accept;

  // two's complement magnitude, most negative maps to 2**31 unsigned
  function automatic imul_pkg::operand_t magnitude(input imul_pkg::operand_t x);
    return x[imul_pkg::op_width-1] ? (~x + 1'b1) : x;
  endfunction

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  // free slot, or the current item leaves on this same edge
  assign mulreq_rdy = !stage_val_q || out.rdy;
  assign accept     = mulreq_val && mulreq_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_val_q <= 1'b0;
    end else if (accept) begin
      stage_val_q <= 1'b1;
    end else if (out.rdy) begin
      // handed over with nothing new behind it
      stage_val_q <= 1'b0;
    end
  end

  // ----------------------------------------
  // payload
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      a_mag_q <= magnitude(mulreq_msg_a);
      b_mag_q <= magnitude(mulreq_msg_b);
      // sign of the product is the xor of the operand signs
      neg_q   <= mulreq_msg_a[imul_pkg::op_width-1] ^ mulreq_msg_b[imul_pkg::op_width-1];
    end
  end

  assign out.a_mag = a_mag_q;
  assign out.b_mag = b_mag_q;
  assign out.neg   = neg_q;
  assign out.val   = stage_val_q;

  // a stalled item must not change under the queue
  a_stage_hold: assert property (@(posedge clk) disable iff (reset)
    (out.val && !out.rdy) |=> (out.val && $stable(out.a_mag) && $stable(out.b_mag)
                               && $stable(out.neg)));

endmodule

// ==== rtl/mul_operand_if.sv ====
/*
  mul_operand_if: one prepared operand pair (magnitudes plus
  result sign) with val/rdy flow control
*/

`timescale 1ns/100ps

interface mul_operand_if;

  // magnitude of operand a and b
  imul_pkg::operand_t a_mag;
  imul_pkg::operand_t b_mag;

  // product must be negated at the end
  logic neg;

  // item moves on an edge where both are high
  logic val;
  logic rdy;

  // producer side holds data and val until rdy
  modport src (output a_mag, output b_mag, output neg, output val, input rdy);

  // consumer side only answers with rdy
  modport dst (input a_mag, input b_mag, input neg, input val, output rdy);

endinterface

// ==== rtl/imul_pkg.sv ====
/*
  imul_pkg: shared widths, queue sizing and data types
  for the iterative signed multiply unit
*/

package imul_pkg;

  // ----------------------------------------
  // datapath widths
  // ----------------------------------------

  // width of each request operand
  localparam int op_width = 32;

  // full product width, twice the operand width
  localparam int res_width = 64;

  // step counter, counts op_width shift-add steps
  localparam int cnt_width = 5;

  // ----------------------------------------
  // operand queue sizing
  // ----------------------------------------

  // entries between the request stage and the multiplier
  localparam int queue_depth = 4;

  // pointer width, depth is a power of two so pointers wrap freely
  localparam int queue_ptr_width = 2;

  // ----------------------------------------
  // data types
  // ----------------------------------------

  // a raw signed operand or its unsigned magnitude
  typedef logic [op_width-1:0] operand_t;

  // one full product
  typedef logic [res_width-1:0] result_t;

endpackage
